// File: hdl/dfa_matcher.sv
`timescale 1ns/1ns
`default_nettype none

`include "scan_defines.svh"

module dfa_matcher (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  load_state,
  input  wire                  new_stream,
  input  scan_pkg::dfa_state_t rd_state,
  input  wire                  chr_valid,
  input  wire  [7:0]           chr,
  output scan_pkg::dfa_state_t cur_state,
  output logic                 accept
);

  import scan_pkg::*;

  // Pattern with the first character in the top byte
  localparam logic [8*`SCAN_PATTERN_LEN-1:0] PATTERN = "login";
  localparam logic [7:0] FIRST_CHR = PATTERN[8*`SCAN_PATTERN_LEN-1 -: 8];
  // State that completes the word on a match
  localparam dfa_state_t LAST_STATE = dfa_state_t'(`SCAN_PATTERN_LEN - 1);

  dfa_state_t state_q;
  dfa_state_t state_nx;
  logic [7:0] exp_chr;
  logic       hit;

  // Transition function
  always_comb
  begin
    // Next expected character for the current state
    exp_chr  = PATTERN[8*(`SCAN_PATTERN_LEN - 1 - int'(state_q)) +: 8];
    hit      = 1'b0;
    state_nx = state_q;
    if (chr == exp_chr)
    begin
      if (state_q == LAST_STATE)
      begin
        // Whole word seen, start over for the next one
        hit      = 1'b1;
        state_nx = '0;
      end
      else
        state_nx = dfa_state_t'(state_q + 1'b1);
    end
    // A mismatching 'l' still begins a new attempt
    else if (chr == FIRST_CHR)
      state_nx = dfa_state_t'(1);
    else
      state_nx = '0;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q <= '0;
      accept  <= 1'b0;
    end
    else if (load_state)
    begin
      // New stream starts from idle, others resume
      state_q <= new_stream ? dfa_state_t'(0) : rd_state;
      accept  <= 1'b0;
    end
    else if (chr_valid)
    begin
      state_q <= state_nx;
      accept  <= hit;
    end
    else
      accept  <= 1'b0;  // single-cycle pulse
  end

  assign cur_state = state_q;

endmodule

`default_nettype wire

// File: hdl/match_tally.sv
`timescale 1ns/1ns
`default_nettype none

`include "scan_defines.svh"

module match_tally (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          pkt_start,
  input  wire                          pkt_end,
  input  wire                          pkt_enable,
  input  wire                          accept,
  input  wire  [`SCAN_STREAM_BITS-1:0] res_stream_in,
  input  wire                          res_ready,
  output logic                         res_valid,
  output logic [`SCAN_STREAM_BITS-1:0] res_stream,
  output logic                         res_fired,
  output logic [`SCAN_COUNT_BITS-1:0]  res_count
);

  logic fired_q;
  logic fired_pkt;

  // Last character's accept arrives together with pkt_end
  assign fired_pkt = (fired_q | accept) & pkt_enable;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      fired_q   <= 1'b0;
      res_valid <= 1'b0;
      res_count <= '0;
    end
    else
    begin
      // Speculative flag for the packet in flight
      if (pkt_start)
        fired_q <= 1'b0;
      else if (accept)
        fired_q <= 1'b1;

      if (pkt_end)
      begin
        // Global count over all streams
        res_count <= res_count + {{(`SCAN_COUNT_BITS-1){1'b0}}, fired_pkt};
        res_valid <= 1'b1;
      end
      else if (res_valid && res_ready)
        res_valid <= 1'b0;
    end
  end

  // Result payload
  // Held until the next packet ends
  always_ff @(posedge clk)
  begin
    if (pkt_end)
    begin
      res_stream <= res_stream_in;
      res_fired  <= fired_pkt;
    end
  end

endmodule

`default_nettype wire

// File: hdl/regex_scan_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "scan_defines.svh"

module regex_scan_top (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          in_valid,
  output logic                         in_ready,
  input  scan_pkg::scan_beat_u         in_data,
  input  wire                          in_first,
  input  wire                          in_last,
  output logic                         res_valid,
  input  wire                          res_ready,
  output logic [`SCAN_STREAM_BITS-1:0] res_stream,
  output logic                         res_fired,
  output logic [`SCAN_COUNT_BITS-1:0]  res_count
);

  import scan_pkg::*;

  // Store read port
  logic                         rd_en;
  logic [`SCAN_STREAM_BITS-1:0] rd_stream;
  dfa_state_t                   rd_state;
  // Store write port, data from the matcher
  logic                         wr_en;
  logic [`SCAN_STREAM_BITS-1:0] wr_stream;
  // Matcher controls
  logic                         load_state;
  logic                         new_stream;
  logic                         chr_valid;
  logic [7:0]                   chr;
  dfa_state_t                   cur_state;
  logic                         accept;
  // Tally strobes
  logic                         pkt_start;
  logic                         pkt_end;
  logic                         pkt_enable;

  stream_sequencer i_sequencer (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_data    (in_data),
    .in_first   (in_first),
    .in_last    (in_last),
    .res_valid  (res_valid),
    .res_ready  (res_ready),
    .rd_en      (rd_en),
    .rd_stream  (rd_stream),
    .wr_en      (wr_en),
    .wr_stream  (wr_stream),
    .load_state (load_state),
    .new_stream (new_stream),
    .chr_valid  (chr_valid),
    .chr        (chr),
    .pkt_start  (pkt_start),
    .pkt_end    (pkt_end),
    .pkt_enable (pkt_enable)
  );

  dfa_matcher i_matcher (
    .clk        (clk),
    .rst_n      (rst_n),
    .load_state (load_state),
    .new_stream (new_stream),
    .rd_state   (rd_state),
    .chr_valid  (chr_valid),
    .chr        (chr),
    .cur_state  (cur_state),
    .accept     (accept)
  );

  stream_state_store i_store (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_en     (rd_en),
    .rd_stream (rd_stream),
    .rd_state  (rd_state),
    .wr_en     (wr_en),
    .wr_stream (wr_stream),
    .wr_state  (cur_state)
  );

  // Packet's stream number doubles as the result stream
  match_tally i_tally (
    .clk           (clk),
    .rst_n         (rst_n),
    .pkt_start     (pkt_start),
    .pkt_end       (pkt_end),
    .pkt_enable    (pkt_enable),
    .accept        (accept),
    .res_stream_in (wr_stream),
    .res_ready     (res_ready),
    .res_valid     (res_valid),
    .res_stream    (res_stream),
    .res_fired     (res_fired),
    .res_count     (res_count)
  );

endmodule

`default_nettype wire

// File: hdl/scan_defines.svh
`ifndef SCAN_DEFINES_SVH
`define SCAN_DEFINES_SVH

// Stream number width
// Eight interleaved telnet streams
`define SCAN_STREAM_BITS 3

// Width of the global fired-packet counter
`define SCAN_COUNT_BITS 16

// Matcher state width
// Holds 0 to 4 matched characters
`define SCAN_STATE_BITS 3

// Length of the literal "login"
`define SCAN_PATTERN_LEN 5

`endif

// File: hdl/scan_pkg.sv
`default_nettype none

package scan_pkg;

  `include "scan_defines.svh"

  // Header view of an input beat
  // Stream number sits in the top bits
  typedef struct packed {
    logic [`SCAN_STREAM_BITS-1:0]    stream;
    // Stream has no saved matcher state
    logic                            new_stream;
    // Packet may report a match and save its state
    logic                            enable;
    logic [16-`SCAN_STREAM_BITS-3:0] rsvd;
  } scan_hdr_t;

  // Payload view of an input beat
  // One character in the low byte
  typedef struct packed {
    logic [7:0] rsvd;
    logic [7:0] chr;
  } scan_chr_t;

  // Input word as seen on the bus
  // Decoded as header on the first beat, as character afterwards
  typedef union packed {
    scan_hdr_t hdr;
    scan_chr_t pay;
  } scan_beat_u;

  // Number of pattern characters matched so far
  typedef logic [`SCAN_STATE_BITS-1:0] dfa_state_t;

endpackage

`default_nettype wire

// File: hdl/stream_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

`include "scan_defines.svh"

module stream_sequencer (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          in_valid,
  output logic                         in_ready,
  input  scan_pkg::scan_beat_u         in_data,
  input  wire                          in_first,
  input  wire                          in_last,
  input  wire                          res_valid,
  input  wire                          res_ready,
  output logic                         rd_en,
  output logic [`SCAN_STREAM_BITS-1:0] rd_stream,
  output logic                         wr_en,
  output logic [`SCAN_STREAM_BITS-1:0] wr_stream,
  output logic                         load_state,
  output logic                         new_stream,
  output logic                         chr_valid,
  output logic [7:0]                   chr,
  output logic                         pkt_start,
  output logic                         pkt_end,
  output logic                         pkt_enable
);

  import scan_pkg::*;

  // Packet phases
  localparam logic [2:0] PH_IDLE    = 3'd0;
  localparam logic [2:0] PH_RESTORE = 3'd1;
  localparam logic [2:0] PH_PAYLOAD = 3'd2;
  localparam logic [2:0] PH_DRAIN   = 3'd3;
  localparam logic [2:0] PH_SCORE   = 3'd4;
  localparam logic [2:0] PH_HOLD    = 3'd5;

  logic [2:0]                   phase_q;
  logic [2:0]                   phase_d;
  logic                         xfer;
  scan_hdr_t                    hdr;
  // Packet context latched from the header
  logic [`SCAN_STREAM_BITS-1:0] stream_q;
  logic                         enable_q;
  logic                         new_q;

  assign xfer = in_valid & in_ready;
  assign hdr  = in_data.hdr;

  always_comb
  begin
    phase_d = phase_q;
    case (phase_q)
      PH_IDLE:
        // Stray payload beats outside a packet are dropped
        if (xfer && in_first)
          phase_d = PH_RESTORE;
      PH_RESTORE:
        phase_d = PH_PAYLOAD;
      PH_PAYLOAD:
        if (xfer && in_last)
          phase_d = PH_DRAIN;
      PH_DRAIN:
        phase_d = PH_SCORE;
      PH_SCORE:
        // Result was just registered by the tally
        if (res_valid && res_ready)
          phase_d = PH_IDLE;
        else
          phase_d = PH_HOLD;
      PH_HOLD:
        if (res_valid && res_ready)
          phase_d = PH_IDLE;
      default:
        phase_d = PH_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      phase_q  <= PH_IDLE;
      in_ready <= 1'b0;
    end
    else
    begin
      phase_q  <= phase_d;
      // Ready only where a beat can be taken next cycle
      in_ready <= (phase_d == PH_IDLE) || (phase_d == PH_PAYLOAD);
    end
  end

  // Header fields held for the whole packet
  always_ff @(posedge clk)
  begin
    if (phase_q == PH_IDLE && xfer && in_first)
    begin
      stream_q <= hdr.stream;
      enable_q <= hdr.enable;
      new_q    <= hdr.new_stream;
    end
  end

  // Store read starts on the header transfer itself
  assign rd_en     = (phase_q == PH_IDLE) & xfer & in_first;
  assign rd_stream = hdr.stream;

  // Restored state lands in the matcher during the stall cycle
  assign load_state = (phase_q == PH_RESTORE);
  assign new_stream = new_q;
  assign pkt_start  = (phase_q == PH_RESTORE);

  // Characters go straight into the registered matcher
  assign chr_valid = (phase_q == PH_PAYLOAD) & xfer;
  assign chr       = in_data.pay.chr;

  // Final accept is visible during drain
  assign pkt_end    = (phase_q == PH_DRAIN);
  assign pkt_enable = enable_q;
  // Disabled packets leave the saved state alone
  assign wr_en      = (phase_q == PH_DRAIN) & enable_q;
  assign wr_stream  = stream_q;

endmodule

`default_nettype wire

// File: hdl/stream_state_store.sv
`timescale 1ns/1ns
`default_nettype none

`include "scan_defines.svh"

module stream_state_store (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          rd_en,
  input  wire  [`SCAN_STREAM_BITS-1:0] rd_stream,
  output scan_pkg::dfa_state_t         rd_state,
  input  wire                          wr_en,
  input  wire  [`SCAN_STREAM_BITS-1:0] wr_stream,
  input  scan_pkg::dfa_state_t         wr_state
);

  import scan_pkg::*;

  // One entry per stream
  localparam int DEPTH = 1 << `SCAN_STREAM_BITS;

  dfa_state_t mem [DEPTH];

  // Saved matcher states
  // All streams read back as idle after reset
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < DEPTH; i++)
      begin
        mem[i] <= '0;
      end
    end
    else if (wr_en)
      mem[wr_stream] <= wr_state;
  end

  // Registered read
  // Data valid the cycle after rd_en
  always_ff @(posedge clk)
  begin
    if (rd_en)
      rd_state <= mem[rd_stream];
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the scanner testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert \
  --top-module tb_regex_scan \
  -f src.f \
  -o sim_tb_regex_scan

status=0
./obj_dir/sim_tb_regex_scan > sim.log 2>&1 || status=$?
cat sim.log

# The log line decides the verdict
if [ "$status" -eq 0 ] && grep -qx "Test OK" sim.log; then
  exit 0
fi
exit 1

// File: src.f
+incdir+hdl
hdl/scan_pkg.sv
hdl/stream_sequencer.sv
hdl/dfa_matcher.sv
hdl/stream_state_store.sv
hdl/match_tally.sv
hdl/regex_scan_top.sv
test/tb_regex_scan.sv

// File: test/tb_regex_scan.sv
`timescale 1ns/1ns
`default_nettype none

`include "scan_defines.svh"

module tb_regex_scan;

  import scan_pkg::*;

  typedef logic [`SCAN_STREAM_BITS-1:0] stream_t;
  typedef logic [`SCAN_COUNT_BITS-1:0]  count_t;

  localparam int CLK_PERIOD    = 4;
  localparam int NUM_DIRECTED  = 13;
  localparam int NUM_RANDOM    = 40;
  localparam int NUM_PKTS      = NUM_DIRECTED + NUM_RANDOM;
  // Header plus up to eight characters
  localparam int MAX_PKT_BEATS = 9;
  localparam int TIMEOUT_NS    = NUM_PKTS * MAX_PKT_BEATS * 8 * CLK_PERIOD;

  logic       clk;
  logic       rst_n;
  logic       in_valid;
  logic       in_ready;
  scan_beat_u in_data;
  logic       in_first;
  logic       in_last;
  logic       res_valid;
  logic       res_ready;
  stream_t    res_stream;
  logic       res_fired;
  count_t     res_count;

  // Expected results in packet order
  stream_t    exp_stream_mem [64];
  logic       exp_fired_mem  [64];
  count_t     exp_count_mem  [64];
  logic [5:0] wr_ptr;
  logic [5:0] rd_ptr;
  stream_t    exp_stream;
  logic       exp_fired;
  count_t     exp_count;

  // Reference model state
  int         model_state [8];
  int         model_count;
  logic [7:0] pkt_chars [$];
  int         errors = 0;

  regex_scan_top i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_data    (in_data),
    .in_first   (in_first),
    .in_last    (in_last),
    .res_valid  (res_valid),
    .res_ready  (res_ready),
    .res_stream (res_stream),
    .res_fired  (res_fired),
    .res_count  (res_count)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Head of the expected queue
  assign exp_stream = exp_stream_mem[rd_ptr];
  assign exp_fired  = exp_fired_mem[rd_ptr];
  assign exp_count  = exp_count_mem[rd_ptr];

  always @(posedge clk)
  begin
    if (!rst_n)
      rd_ptr <= '0;
    else if (res_valid && res_ready)
      rd_ptr <= rd_ptr + 6'd1;
  end

  // Result checks on every accepted result
  chk_stream: assert property (@(posedge clk) disable iff (!rst_n)
    res_valid && res_ready |-> res_stream == exp_stream)
    else
    begin
      errors = errors + 1;
      $display("CHECK FAILED at %0t ns: res_stream = %0d, expected %0d",
               $time, $sampled(res_stream), $sampled(exp_stream));
    end

  chk_fired: assert property (@(posedge clk) disable iff (!rst_n)
    res_valid && res_ready |-> res_fired == exp_fired)
    else
    begin
      errors = errors + 1;
      $display("CHECK FAILED at %0t ns: res_fired = %0b, expected %0b",
               $time, $sampled(res_fired), $sampled(exp_fired));
    end

  chk_count: assert property (@(posedge clk) disable iff (!rst_n)
    res_valid && res_ready |-> res_count == exp_count)
    else
    begin
      errors = errors + 1;
      $display("CHECK FAILED at %0t ns: res_count = %0d, expected %0d",
               $time, $sampled(res_count), $sampled(exp_count));
    end

  // One result per packet, never more
  chk_extra: assert property (@(posedge clk) disable iff (!rst_n)
    res_valid && res_ready |-> rd_ptr != wr_ptr)
    else
    begin
      errors = errors + 1;
      $display("Result at %0t ns arrived with no packet outstanding", $time);
    end

  // Held result must not move
  chk_hold: assert property (@(posedge clk) disable iff (!rst_n)
    res_valid && !res_ready |=> res_valid && $stable(res_stream)
      && $stable(res_fired) && $stable(res_count))
    else
    begin
      errors = errors + 1;
      $display("Result changed at %0t ns while res_ready was low", $time);
    end

  // Input stalls while a result waits
  chk_stall: assert property (@(posedge clk) disable iff (!rst_n)
    res_valid && !res_ready |-> !(in_valid && in_ready))
    else
    begin
      errors = errors + 1;
      $display("Beat transferred at %0t ns while a result was held", $time);
    end

  // Matched prefix length after one character
  function automatic int dfa_step(input int s, input logic [7:0] c, output bit hit);
    string pat;
    pat = "login";
    hit = 1'b0;
    if (c == pat[s])
    begin
      if (s == pat.len() - 1)
      begin
        hit = 1'b1;
        return 0;
      end
      return s + 1;
    end
    // Restart on a stray 'l'
    if (c == pat[0])
      return 1;
    return 0;
  endfunction

  // Beat held until in_ready is seen
  task automatic send_beat(input scan_beat_u data, input logic first, input logic last);
    in_data  = data;
    in_first = first;
    in_last  = last;
    in_valid = 1'b1;
    while (!in_ready)
    begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    in_valid = 1'b0;
    in_first = 1'b0;
    in_last  = 1'b0;
  endtask

  // Model the packet, queue its result, then drive it
  task automatic send_packet(input stream_t stream, input logic new_s, input logic en);
    scan_beat_u beat;
    int         s;
    bit         hit;
    bit         fired;
    s     = new_s ? 0 : model_state[stream];
    fired = 1'b0;
    foreach (pkt_chars[i])
    begin
      s     = dfa_step(s, pkt_chars[i], hit);
      fired = fired | hit;
    end
    // Disabled packets neither count nor save
    if (en)
    begin
      model_state[stream] = s;
      if (fired)
        model_count = model_count + 1;
    end
    exp_stream_mem[wr_ptr] = stream;
    exp_fired_mem[wr_ptr]  = fired & en;
    exp_count_mem[wr_ptr]  = count_t'(model_count);
    wr_ptr                 = wr_ptr + 6'd1;
    beat                = '0;
    beat.hdr.stream     = stream;
    beat.hdr.new_stream = new_s;
    beat.hdr.enable     = en;
    send_beat(beat, 1'b1, 1'b0);
    foreach (pkt_chars[i])
    begin
      beat         = '0;
      beat.pay.chr = pkt_chars[i];
      send_beat(beat, 1'b0, i == pkt_chars.size() - 1);
    end
  endtask

  task automatic directed_packet(input stream_t stream, input logic new_s, input logic en,
                                 input string text);
    pkt_chars.delete();
    for (int i = 0; i < text.len(); i++)
      pkt_chars.push_back(text[i]);
    send_packet(stream, new_s, en);
  endtask

  // Small alphabet so words and splits show up often
  task automatic random_packet();
    string alpha;
    int    len;
    alpha = "loginx";
    len   = 1 + int'($urandom % 8);
    pkt_chars.delete();
    repeat (len) pkt_chars.push_back(alpha[int'($urandom % 6)]);
    send_packet(stream_t'($urandom), ($urandom % 8) == 0, ($urandom % 8) != 0);
  endtask

  // Random back-pressure on the result port
  initial
  begin
    res_ready = 1'b0;
    wait (rst_n === 1'b1);
    forever
    begin
      @(posedge clk);
      #1;
      res_ready = ($urandom % 3) != 0;
    end
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("Timeout after %0d ns with results still outstanding", TIMEOUT_NS);
    $display("Test FAILED");
    $finish;
  end

  initial
  begin
    void'($urandom(32'h2268_4150));
    rst_n       = 1'b0;
    in_valid    = 1'b0;
    in_data     = '0;
    in_first    = 1'b0;
    in_last     = 1'b0;
    wr_ptr      = '0;
    model_count = 0;
    foreach (model_state[i])
      model_state[i] = 0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Whole word, then no word
    directed_packet(3'd0, 1'b1, 1'b1, "xloginx");
    directed_packet(3'd1, 1'b1, 1'b1, "xxgo");
    // Split across packets, resumed and then restarted
    directed_packet(3'd2, 1'b1, 1'b1, "xlo");
    directed_packet(3'd2, 1'b0, 1'b1, "gin");
    directed_packet(3'd3, 1'b1, 1'b1, "xlo");
    directed_packet(3'd3, 1'b1, 1'b1, "gin");
    // Disabled packet leaves the saved "lo" in place
    directed_packet(3'd4, 1'b1, 1'b1, "lo");
    directed_packet(3'd4, 1'b0, 1'b0, "ginlogin");
    directed_packet(3'd4, 1'b0, 1'b1, "gin");
    // Two streams interleaved mid-word
    directed_packet(3'd5, 1'b1, 1'b1, "lo");
    directed_packet(3'd6, 1'b1, 1'b1, "log");
    directed_packet(3'd5, 1'b0, 1'b1, "gin");
    directed_packet(3'd6, 1'b0, 1'b1, "in");

    repeat (NUM_RANDOM) random_packet();

    wait (rd_ptr == wr_ptr);
    repeat (4) @(posedge clk);
    $display("Checked %0d results, %0d errors", rd_ptr, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire
